// File: hw/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// data word width
`define XLEN 32

// ALU op field, top bit marks an invalid op
`define ALU_OP_W 5

// register file index
`define REG_IDX_W 5

// bytes per instruction
`define PC_STEP 4

`endif

// File: hw/cpu_pkg.sv
`include "cpu_macros.svh"

package cpu_pkg;

    typedef logic [`XLEN-1:0]      word_t;
    typedef logic [1:0]            flags_t;   // [1] negative, [0] zero
    typedef logic [`REG_IDX_W-1:0] reg_idx_t;
    typedef logic [`ALU_OP_W-1:0]  alu_op_t;
    typedef logic [1:0]            fwd_sel_t;

    // operand source selects
    localparam fwd_sel_t FWD_DEC = 2'd0;
    localparam fwd_sel_t FWD_EXM = 2'd1;
    localparam fwd_sel_t FWD_WB  = 2'd2;
    localparam fwd_sel_t FWD_LR  = 2'd3;

    typedef struct packed {
        logic     valid;
        logic     branch;
        logic     jump;
        alu_op_t  alu_op;
        logic     alu_src;      // 0 takes the immediate
        logic     mem_wrt;
        logic     mem_en;
        logic     reg_wrt_en;
        logic [1:0] result_sel;
        word_t    pc;
        word_t    reg_1;
        word_t    reg_2;
        word_t    imm;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        logic     fl_wrt_en;
        logic     lr_wrt_en;
        flags_t   fl;           // read in decode
        word_t    lr;
    } dex_t;

    typedef struct packed {
        logic     valid;
        word_t    alu_out;
        word_t    pc_next;
        word_t    reg_2_data;
        word_t    lr_wrt_data;
        flags_t   fl_wrt_data;
        reg_idx_t rd;
        logic     reg_wrt_en;
        logic     fl_wrt_en;
        logic     lr_wrt_en;
        logic     mem_wrt;
        logic     mem_en;
        logic [1:0] result_sel;
    } exm_t;

    typedef struct packed {
        logic     valid;
        word_t    wrt_data;
        word_t    lr_wrt_data;
        flags_t   fl_wrt_data;
        reg_idx_t rd;
        logic     reg_wrt_en;
        logic     fl_wrt_en;
        logic     lr_wrt_en;
    } mwb_t;

    typedef struct packed {
        fwd_sel_t sel_a;
        fwd_sel_t sel_b;
        logic     sel_lr;       // 0 exm, 1 mwb
        logic     use_lr_fwd;
        fwd_sel_t sel_fl;
    } fwd_t;

endpackage

// File: hw/forward_unit.sv
`timescale 1ns/1ps

module forward_unit import cpu_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  dex_t dex,
    input  exm_t exm_q,
    input  mwb_t mwb_q,
    output fwd_t fwd
);

    logic exm_wr;
    logic mwb_wr;
    logic a_exm;
    logic a_mwb;
    logic b_exm;
    logic b_mwb;
    logic is_ret;

    // register writes still in flight
    assign exm_wr = exm_q.valid && exm_q.reg_wrt_en;
    assign mwb_wr = mwb_q.valid && mwb_q.reg_wrt_en;

    // r0 is hardwired, never forward it
    assign a_exm = exm_wr && (exm_q.rd == dex.rs1) && (dex.rs1 != '0);
    assign a_mwb = mwb_wr && (mwb_q.rd == dex.rs1) && (dex.rs1 != '0);
    assign b_exm = exm_wr && (exm_q.rd == dex.rs2) && (dex.rs2 != '0);
    assign b_mwb = mwb_wr && (mwb_q.rd == dex.rs2) && (dex.rs2 != '0);

    assign is_ret = dex.jump && (dex.alu_op[1:0] == 2'd3);

    always_comb begin
        // newest producer wins
        if (is_ret)
            fwd.sel_a = FWD_LR;       // return target is the LR
        else if (a_exm)
            fwd.sel_a = FWD_EXM;
        else if (a_mwb)
            fwd.sel_a = FWD_WB;
        else
            fwd.sel_a = FWD_DEC;

        if (b_exm)
            fwd.sel_b = FWD_EXM;
        else if (b_mwb)
            fwd.sel_b = FWD_WB;
        else
            fwd.sel_b = FWD_DEC;

        fwd.use_lr_fwd = 1'b1;
        fwd.sel_lr     = 1'b0;
        if (exm_q.valid && exm_q.lr_wrt_en)
            fwd.sel_lr = 1'b0;
        else if (mwb_q.valid && mwb_q.lr_wrt_en)
            fwd.sel_lr = 1'b1;
        else
            fwd.use_lr_fwd = 1'b0;    // decode LR

        if (exm_q.valid && exm_q.fl_wrt_en)
            fwd.sel_fl = FWD_EXM;
        else if (mwb_q.valid && mwb_q.fl_wrt_en)
            fwd.sel_fl = FWD_WB;
        else
            fwd.sel_fl = FWD_DEC;
    end

    // operand B has no LR path in the muxes
    sel_b_no_lr: assert property (@(posedge clk) disable iff (rst) fwd.sel_b != FWD_LR);

endmodule

// File: hw/operand_mux.sv
`timescale 1ns/1ps

module operand_mux import cpu_pkg::*; (
    input  dex_t   dex,
    input  fwd_t   fwd,
    input  exm_t   exm_q,
    input  word_t  wb_data,
    input  mwb_t   mwb_q,
    output word_t  alu_a,
    output word_t  alu_b,
    output word_t  reg_2_fwd,
    output flags_t fl_fwd,
    output word_t  lr_fwd
);

    // LR from the newest writer, else what decode read
    always_comb begin
        if (!fwd.use_lr_fwd)
            lr_fwd = dex.lr;
        else if (fwd.sel_lr)
            lr_fwd = mwb_q.lr_wrt_data;
        else
            lr_fwd = exm_q.lr_wrt_data;
    end

    always_comb begin
        case (fwd.sel_a)
            FWD_EXM: alu_a = exm_q.alu_out;
            FWD_WB:  alu_a = wb_data;
            FWD_LR:  alu_a = lr_fwd;
            default: alu_a = dex.reg_1;
        endcase
    end

    always_comb begin
        case (fwd.sel_b)
            FWD_EXM: reg_2_fwd = exm_q.alu_out;
            FWD_WB:  reg_2_fwd = wb_data;
            FWD_LR:  reg_2_fwd = '0;      // no LR path for B
            default: reg_2_fwd = dex.reg_2;
        endcase
    end

    always_comb begin
        case (fwd.sel_fl)
            FWD_EXM: fl_fwd = exm_q.fl_wrt_data;
            FWD_WB:  fl_fwd = mwb_q.fl_wrt_data;
            default: fl_fwd = dex.fl;
        endcase
    end

    // stores still see the forwarded reg_2 via reg_2_fwd
    assign alu_b = dex.alu_src ? reg_2_fwd : dex.imm;

endmodule

// File: hw/alu.sv
`timescale 1ns/1ps

`include "cpu_macros.svh"

module alu import cpu_pkg::*; (
    input  word_t                a,
    input  word_t                b,
    input  logic [`ALU_OP_W-2:0] op,
    output word_t                result
);

    localparam logic [`ALU_OP_W-2:0] OP_ADD  = 4'd0;
    localparam logic [`ALU_OP_W-2:0] OP_SUB  = 4'd1;
    localparam logic [`ALU_OP_W-2:0] OP_AND  = 4'd2;
    localparam logic [`ALU_OP_W-2:0] OP_OR   = 4'd3;
    localparam logic [`ALU_OP_W-2:0] OP_XOR  = 4'd4;
    localparam logic [`ALU_OP_W-2:0] OP_SLL  = 4'd5;
    localparam logic [`ALU_OP_W-2:0] OP_SRL  = 4'd6;
    localparam logic [`ALU_OP_W-2:0] OP_SRA  = 4'd7;
    localparam logic [`ALU_OP_W-2:0] OP_SLT  = 4'd8;
    localparam logic [`ALU_OP_W-2:0] OP_PASS = 4'd9;

    logic [4:0] shamt;
    logic       lt;

    assign shamt = b[4:0];
    assign lt    = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            OP_ADD:
                result = a + b;
            OP_SUB:
                result = a - b;
            OP_AND:
                result = a & b;
            OP_OR:
                result = a | b;
            OP_XOR:
                result = a ^ b;
            OP_SLL:
                result = a << shamt;
            OP_SRL:
                result = a >> shamt;
            OP_SRA:
                result = word_t'($signed(a) >>> shamt);
            OP_SLT:
                result = {{(`XLEN-1){1'b0}}, lt};
            OP_PASS:
                result = b;   // immediate moves
            default:
                result = '0;  // unused codes and the error code
        endcase
    end

endmodule

// File: hw/branch_jump.sv
`timescale 1ns/1ps

`include "cpu_macros.svh"

module branch_jump import cpu_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       branch,
    input  logic       jump,
    input  flags_t     fl,
    input  word_t      pc,
    input  word_t      imm,
    input  word_t      reg_a,
    input  logic [1:0] op,
    output word_t      pc_next,
    output word_t      lr_wrt_data
);

    word_t pc_4;
    word_t pc_rel;
    logic  taken;

    assign pc_4   = pc + `PC_STEP;
    assign pc_rel = pc + imm + `PC_STEP;   // relative to the next instruction

    // branch condition on the forwarded flags
    always_comb begin
        case (op)
            2'd0:    taken = fl[0];     // eq
            2'd1:    taken = !fl[0];    // ne
            2'd2:    taken = fl[1];     // lt
            default: taken = 1'b1;
        endcase
    end

    always_comb begin
        pc_next = pc_4;
        if (jump) begin
            case (op)
                2'd0:    pc_next = pc_rel;
                2'd1:    pc_next = reg_a;   // jump register
                2'd2:    pc_next = pc_rel;  // call
                default: pc_next = reg_a;   // return, reg_a holds the LR
            endcase
        end else if (branch && taken) begin
            pc_next = pc_rel;
        end
    end

    // only a call commits it, via lr_wrt_en
    assign lr_wrt_data = pc_4;

    br_jmp_excl: assert property (@(posedge clk) disable iff (rst) !(branch && jump));

endmodule

// File: hw/execute.sv
`timescale 1ns/1ps

`include "cpu_macros.svh"

module execute import cpu_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  dex_t dex,
    input  fwd_t fwd,
    input  exm_t exm_q,
    input  mwb_t mwb_q,
    output exm_t exm_d
);

    word_t  alu_a;
    word_t  alu_b;
    word_t  reg_2_fwd;
    flags_t fl_fwd;
    word_t  alu_out;
    word_t  pc_next;
    word_t  lr_wrt_data;
    logic [`ALU_OP_W-2:0] alu_op;

    // the return target reaches branch_jump through alu_a
    operand_mux i_operand_mux (
        .dex       (dex           ),
        .fwd       (fwd           ),
        .exm_q     (exm_q         ),
        .wb_data   (mwb_q.wrt_data),
        .mwb_q     (mwb_q         ),
        .alu_a     (alu_a         ),
        .alu_b     (alu_b         ),
        .reg_2_fwd (reg_2_fwd     ),
        .fl_fwd    (fl_fwd        ),
        .lr_fwd    (              )
    );

    // invalid ops fold onto the error code
    assign alu_op = dex.alu_op[`ALU_OP_W-1] ? 4'hf : dex.alu_op[`ALU_OP_W-2:0];

    alu i_alu (
        .a      (alu_a  ),
        .b      (alu_b  ),
        .op     (alu_op ),
        .result (alu_out)
    );

    branch_jump i_branch_jump (
        .clk         (clk              ),
        .rst         (rst              ),
        .branch      (dex.branch       ),
        .jump        (dex.jump         ),
        .fl          (fl_fwd           ),
        .pc          (dex.pc           ),
        .imm         (dex.imm          ),
        .reg_a       (alu_a            ),
        .op          (dex.alu_op[1:0]  ),
        .pc_next     (pc_next          ),
        .lr_wrt_data (lr_wrt_data      )
    );

    always_comb begin
        exm_d.valid          = dex.valid;
        exm_d.alu_out        = alu_out;
        exm_d.pc_next        = pc_next;
        exm_d.reg_2_data     = reg_2_fwd;
        exm_d.lr_wrt_data    = lr_wrt_data;
        exm_d.fl_wrt_data[0] = (alu_out == '0);
        exm_d.fl_wrt_data[1] = alu_out[`XLEN-1];
        exm_d.rd             = dex.rd;
        // bubbles carry no writes
        exm_d.reg_wrt_en     = dex.valid && dex.reg_wrt_en;
        exm_d.fl_wrt_en      = dex.valid && dex.fl_wrt_en;
        exm_d.lr_wrt_en      = dex.valid && dex.lr_wrt_en;
        exm_d.mem_wrt        = dex.valid && dex.mem_wrt;
        exm_d.mem_en         = dex.valid && dex.mem_en;
        exm_d.result_sel     = dex.result_sel;
    end

    // decode must not let an invalid op write the register file
    bad_op_no_wr: assert property (@(posedge clk) disable iff (rst)
        dex.valid |-> !(dex.alu_op[`ALU_OP_W-1] && dex.reg_wrt_en));

endmodule

// File: hw/exec_pipe.sv
`timescale 1ns/1ps

module exec_pipe import cpu_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  dex_t dex,
    output exm_t exm_q,
    output mwb_t mwb_q
);

    fwd_t fwd;
    exm_t exm_d;
    mwb_t mwb_d;

    forward_unit i_forward_unit (
        .clk   (clk  ),
        .rst   (rst  ),
        .dex   (dex  ),
        .exm_q (exm_q),
        .mwb_q (mwb_q),
        .fwd   (fwd  )
    );

    execute i_execute (
        .clk   (clk  ),
        .rst   (rst  ),
        .dex   (dex  ),
        .fwd   (fwd  ),
        .exm_q (exm_q),
        .mwb_q (mwb_q),
        .exm_d (exm_d)
    );

    // memory stage only hands results on
    always_comb begin
        mwb_d.valid       = exm_q.valid;
        mwb_d.wrt_data    = exm_q.alu_out;
        mwb_d.lr_wrt_data = exm_q.lr_wrt_data;
        mwb_d.fl_wrt_data = exm_q.fl_wrt_data;
        mwb_d.rd          = exm_q.rd;
        mwb_d.reg_wrt_en  = exm_q.reg_wrt_en;
        mwb_d.fl_wrt_en   = exm_q.fl_wrt_en;
        mwb_d.lr_wrt_en   = exm_q.lr_wrt_en;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            exm_q <= '0;   // valid and all enables low
        end else begin
            exm_q <= exm_d;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mwb_q <= '0;
        end else begin
            mwb_q <= mwb_d;
        end
    end

endmodule

// File: sim/exec_pipe_tb.sv
`timescale 1ns/1ps

module exec_pipe_tb import cpu_pkg::*; ();

    typedef struct packed {
        word_t  alu_out;
        word_t  pc_next;
        word_t  reg_2_data;
        word_t  lr_wrt_data;
        flags_t fl_wrt_data;
    } expect_t;

    logic    clk;
    logic    rst;
    dex_t    dex;
    exm_t    exm_q;
    mwb_t    mwb_q;

    string   row_name[$];
    dex_t    row_dex[$];
    expect_t row_exp[$];

    integer  seed = 32'h4894_3afb;
    int      pass_cnt = 0;
    int      fail_cnt = 0;
    int      cycle_cnt = 0;
    int      cycle_limit = 0;
    logic    table_ready = 1'b0;

    exec_pipe dut_i (
        .clk   (clk  ),
        .rst   (rst  ),
        .dex   (dex  ),
        .exm_q (exm_q),
        .mwb_q (mwb_q)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // newest producer first and r0 never forwarded
    function automatic word_t pick_reg(input reg_idx_t rs, input word_t dec, input dex_t p1,
                                       input expect_t e1, input dex_t p2, input expect_t e2);
        if (rs != 5'd0 && p1.valid && p1.reg_wrt_en && p1.rd == rs)
            return e1.alu_out;
        else if (rs != 5'd0 && p2.valid && p2.reg_wrt_en && p2.rd == rs)
            return e2.alu_out;
        return dec;
    endfunction

    // p1 sits in exm and p2 in mwb while cur executes
    function automatic expect_t predict(input dex_t cur, input dex_t p1, input expect_t e1,
                                        input dex_t p2, input expect_t e2);
        expect_t e;
        word_t   a;
        word_t   b;
        word_t   r2;
        word_t   lr;
        word_t   res;
        flags_t  fl;
        logic    taken;
        if (p1.valid && p1.lr_wrt_en)
            lr = e1.lr_wrt_data;
        else if (p2.valid && p2.lr_wrt_en)
            lr = e2.lr_wrt_data;
        else
            lr = cur.lr;
        if (p1.valid && p1.fl_wrt_en)
            fl = e1.fl_wrt_data;
        else if (p2.valid && p2.fl_wrt_en)
            fl = e2.fl_wrt_data;
        else
            fl = cur.fl;
        a = pick_reg(cur.rs1, cur.reg_1, p1, e1, p2, e2);
        if (cur.jump && cur.alu_op[1:0] == 2'd3)
            a = lr;   // return
        r2 = pick_reg(cur.rs2, cur.reg_2, p1, e1, p2, e2);
        b = cur.alu_src ? r2 : cur.imm;
        res = '0;
        if (!cur.alu_op[4]) begin
            case (cur.alu_op[3:0])
                4'd0: res = a + b;
                4'd1: res = a - b;
                4'd2: res = a & b;
                4'd3: res = a | b;
                4'd4: res = a ^ b;
                4'd5: res = a << b[4:0];
                4'd6: res = a >> b[4:0];
                4'd7: res = word_t'($signed(a) >>> b[4:0]);
                4'd8: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                4'd9: res = b;
                default: res = '0;
            endcase
        end
        case (cur.alu_op[1:0])
            2'd0: taken = fl[0];
            2'd1: taken = !fl[0];
            2'd2: taken = fl[1];
            default: taken = 1'b1;
        endcase
        e.alu_out     = res;
        e.reg_2_data  = r2;
        e.lr_wrt_data = cur.pc + 32'd4;
        e.fl_wrt_data = {res[31], res == 32'd0};
        e.pc_next     = cur.pc + 32'd4;
        if (cur.jump)
            e.pc_next = cur.alu_op[0] ? a : cur.pc + cur.imm + 32'd4;
        else if (cur.branch && taken)
            e.pc_next = cur.pc + cur.imm + 32'd4;
        return e;
    endfunction

    function automatic dex_t alu_row(input alu_op_t op, input logic alu_src,
                                     input reg_idx_t rs1, input reg_idx_t rs2,
                                     input reg_idx_t rd);
        dex_t d;
        d            = '0;
        d.valid      = 1'b1;
        d.alu_op     = op;
        d.alu_src    = alu_src;
        d.reg_wrt_en = 1'b1;
        d.rs1        = rs1;
        d.rs2        = rs2;
        d.rd         = rd;
        d.pc         = $random(seed) & 32'h0000_fffc;
        d.reg_1      = $random(seed);
        d.reg_2      = $random(seed);
        d.imm        = $random(seed);
        d.lr         = $random(seed);
        d.fl         = flags_t'($random(seed));
        d.result_sel = 2'($random(seed));
        return d;
    endfunction

    // every enable set, only valid or reset keeps it out
    function automatic dex_t enables_row(input logic valid);
        dex_t d;
        d            = '0;
        d.valid      = valid;
        d.reg_wrt_en = 1'b1;
        d.fl_wrt_en  = 1'b1;
        d.lr_wrt_en  = 1'b1;
        d.mem_wrt    = 1'b1;
        d.mem_en     = 1'b1;
        d.rd         = 5'd1;
        return d;
    endfunction

    function automatic dex_t branch_row(input logic [1:0] cond, input flags_t fl);
        dex_t d;
        d            = alu_row({3'b000, cond}, 1'b1, 5'd0, 5'd0, 5'd0);
        d.branch     = 1'b1;
        d.reg_wrt_en = 1'b0;
        d.fl         = fl;   // decode view of the flags
        return d;
    endfunction

    function automatic dex_t jump_row(input logic [1:0] kind, input reg_idx_t rs1);
        dex_t d;
        d            = alu_row({3'b000, kind}, 1'b1, rs1, 5'd0, 5'd0);
        d.jump       = 1'b1;
        d.reg_wrt_en = 1'b0;
        d.lr_wrt_en  = (kind == 2'd2);   // call
        return d;
    endfunction

    function automatic dex_t store_row(input reg_idx_t rs2);
        dex_t d;
        d            = alu_row(5'd0, 1'b0, 5'd0, rs2, 5'd0);
        d.reg_wrt_en = 1'b0;
        d.mem_wrt    = 1'b1;
        d.mem_en     = 1'b1;
        return d;
    endfunction

    task automatic add_row(input string name, input dex_t d);
        dex_t    p1;
        dex_t    p2;
        expect_t e1;
        expect_t e2;
        int      n;
        p1 = '0;
        p2 = '0;
        e1 = '0;
        e2 = '0;
        n  = row_dex.size();
        if (n > 0) begin
            p1 = row_dex[n - 1];
            e1 = row_exp[n - 1];
        end
        if (n > 1) begin
            p2 = row_dex[n - 2];
            e2 = row_exp[n - 2];
        end
        row_name.push_back(name);
        row_dex.push_back(d);
        row_exp.push_back(predict(d, p1, e1, p2, e2));
    endtask

    task automatic build_table();
        dex_t d;
        for (int k = 0; k < 10; k++) begin
            d = alu_row(alu_op_t'(k), 1'b1, 5'd0, 5'd0, reg_idx_t'(k + 1));
            d.fl_wrt_en = 1'b1;
            add_row($sformatf("alu_op_%0d", k), d);
        end
        d = alu_row(5'h10, 1'b1, 5'd0, 5'd0, 5'd0);
        d.reg_wrt_en = 1'b0;
        add_row("bad_op_10", d);
        d = alu_row(5'h1f, 1'b1, 5'd0, 5'd0, 5'd0);
        d.reg_wrt_en = 1'b0;
        add_row("bad_op_1f", d);
        add_row("unused_op_12", alu_row(5'd12, 1'b1, 5'd0, 5'd0, 5'd0));
        // forwarding
        add_row("fwd_producer", alu_row(5'd0, 1'b0, 5'd0, 5'd0, 5'd5));
        add_row("fwd_exm_a", alu_row(5'd0, 1'b1, 5'd5, 5'd0, 5'd6));
        add_row("fwd_wb_a_exm_b", alu_row(5'd1, 1'b1, 5'd5, 5'd6, 5'd8));
        add_row("fwd_old_r7", alu_row(5'd9, 1'b0, 5'd0, 5'd0, 5'd7));
        add_row("fwd_new_r7", alu_row(5'd9, 1'b0, 5'd0, 5'd0, 5'd7));
        add_row("fwd_newest_wins", alu_row(5'd0, 1'b1, 5'd7, 5'd7, 5'd9));
        add_row("write_r0", alu_row(5'd9, 1'b0, 5'd0, 5'd0, 5'd0));
        add_row("no_fwd_r0", alu_row(5'd4, 1'b1, 5'd0, 5'd0, 5'd10));
        // branches on forwarded and decode flags
        d = alu_row(5'd1, 1'b1, 5'd0, 5'd0, 5'd11);
        d.reg_2     = d.reg_1;
        d.fl_wrt_en = 1'b1;
        add_row("flag_zero_sub", d);
        add_row("beq_fwd_exm", branch_row(2'd0, 2'b00));
        add_row("bne_fwd_wb", branch_row(2'd1, 2'b00));
        d = alu_row(5'd1, 1'b1, 5'd0, 5'd0, 5'd11);
        d.reg_1     = 32'd5;
        d.reg_2     = 32'd9;
        d.fl_wrt_en = 1'b1;
        add_row("flag_neg_sub", d);
        add_row("blt_fwd_exm", branch_row(2'd2, 2'b00));
        add_row("beq_fwd_wb_neg", branch_row(2'd0, 2'b01));
        add_row("beq_decode", branch_row(2'd0, 2'b01));
        add_row("blt_decode_not", branch_row(2'd2, 2'b00));
        add_row("b_always", branch_row(2'd3, 2'b00));
        // calls, returns and jumps
        add_row("jr_target", alu_row(5'd0, 1'b0, 5'd0, 5'd0, 5'd12));
        add_row("jr_fwd_exm", jump_row(2'd1, 5'd12));
        add_row("call", jump_row(2'd2, 5'd0));
        add_row("ret_fwd_exm", jump_row(2'd3, 5'd0));
        add_row("jump_rel", jump_row(2'd0, 5'd0));
        add_row("call_2", jump_row(2'd2, 5'd0));
        add_row("filler", alu_row(5'd0, 1'b1, 5'd0, 5'd0, 5'd13));
        add_row("ret_fwd_wb", jump_row(2'd3, 5'd0));
        add_row("ret_decode", jump_row(2'd3, 5'd0));
        // stores
        add_row("store_data_src", alu_row(5'd9, 1'b0, 5'd0, 5'd0, 5'd14));
        add_row("store_fwd_exm", store_row(5'd14));
        add_row("store_fwd_wb", store_row(5'd14));
    endtask

    task automatic compare_word(input string test, input string field, input word_t exp,
                                input word_t act, inout int errs);
        if (act !== exp) begin
            $display("[FAIL] %s %s expected %h actual %h", test, field, exp, act);
            errs++;
        end
    endtask

    task automatic check_row(input int i);
        expect_t e;
        expect_t pe;
        dex_t    d;
        dex_t    p;
        int      errs;
        e    = row_exp[i];
        d    = row_dex[i];
        errs = 0;
        if (exm_q.valid !== 1'b1) begin
            $display("[FAIL] %s valid expected 1 actual %b", row_name[i], exm_q.valid);
            errs++;
        end
        compare_word(row_name[i], "alu_out", e.alu_out, exm_q.alu_out, errs);
        compare_word(row_name[i], "pc_next", e.pc_next, exm_q.pc_next, errs);
        compare_word(row_name[i], "reg_2_data", e.reg_2_data, exm_q.reg_2_data, errs);
        compare_word(row_name[i], "lr_wrt_data", e.lr_wrt_data, exm_q.lr_wrt_data, errs);
        compare_word(row_name[i], "fl_wrt_data", {30'd0, e.fl_wrt_data},
                     {30'd0, exm_q.fl_wrt_data}, errs);
        compare_word(row_name[i], "exm_ctrl",
                     {20'd0, d.rd, d.reg_wrt_en, d.fl_wrt_en, d.lr_wrt_en, d.mem_wrt,
                      d.mem_en, d.result_sel},
                     {20'd0, exm_q.rd, exm_q.reg_wrt_en, exm_q.fl_wrt_en, exm_q.lr_wrt_en,
                      exm_q.mem_wrt, exm_q.mem_en, exm_q.result_sel}, errs);
        // mwb_q holds the row before, or the idle bubble
        if (i > 0) begin
            p  = row_dex[i - 1];
            pe = row_exp[i - 1];
            compare_word(row_name[i], "mwb_wrt_data", pe.alu_out, mwb_q.wrt_data, errs);
            compare_word(row_name[i], "mwb_lr_wrt_data", pe.lr_wrt_data, mwb_q.lr_wrt_data,
                         errs);
            compare_word(row_name[i], "mwb_ctrl",
                         {21'd0, p.valid, pe.fl_wrt_data, p.rd, p.reg_wrt_en, p.fl_wrt_en,
                          p.lr_wrt_en},
                         {21'd0, mwb_q.valid, mwb_q.fl_wrt_data, mwb_q.rd, mwb_q.reg_wrt_en,
                          mwb_q.fl_wrt_en, mwb_q.lr_wrt_en}, errs);
        end else if (mwb_q.valid !== 1'b0) begin
            $display("[FAIL] %s mwb valid expected 0 actual %b", row_name[i], mwb_q.valid);
            errs++;
        end
        if (errs == 0) begin
            pass_cnt++;
            $display("[ok]   %s", row_name[i]);
        end else begin
            fail_cnt++;
        end
    endtask

    // first sample right after reset, then two cycles of bubbles
    task automatic check_idle();
        logic [9:0] bits;
        int         errs;
        errs = 0;
        for (int c = 0; c < 3; c++) begin
            @(negedge clk);
            bits = {exm_q.valid, exm_q.reg_wrt_en, exm_q.fl_wrt_en, exm_q.lr_wrt_en,
                    exm_q.mem_wrt, exm_q.mem_en, mwb_q.valid, mwb_q.reg_wrt_en,
                    mwb_q.fl_wrt_en, mwb_q.lr_wrt_en};
            if (bits !== 10'd0) begin
                $display("[FAIL] idle_after_reset valid/enable bits expected %b actual %b",
                         10'd0, bits);
                errs++;
            end
        end
        if (errs == 0) begin
            pass_cnt++;
            $display("[ok]   idle_after_reset");
        end else begin
            fail_cnt++;
        end
    endtask

    initial begin
        wait (table_ready);
        while (cycle_cnt <= cycle_limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: the run went past %0d cycles without finishing", cycle_limit);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        dex <= enables_row(1'b1);   // live row that reset has to hold off
        rst <= 1'b1;
        build_table();
        cycle_limit = row_dex.size() + 10;
        table_ready = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        dex <= enables_row(1'b0);
        check_idle();
        // one row per clock and each checked once it lands in exm_q
        for (int i = 0; i <= row_dex.size(); i++) begin
            @(posedge clk);
            if (i < row_dex.size())
                dex <= row_dex[i];
            else
                dex <= '0;
            if (i > 0) begin
                @(negedge clk);
                check_row(i - 1);
            end
        end
        $display("tests: %0d run, %0d passed, %0d failed",
                 pass_cnt + fail_cnt, pass_cnt, fail_cnt);
        if (fail_cnt == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

// File: exec_pipe.f
+incdir+hw
hw/cpu_pkg.sv
hw/forward_unit.sv
hw/operand_mux.sv
hw/alu.sv
hw/branch_jump.sv
hw/execute.sv
hw/exec_pipe.sv
sim/exec_pipe_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it, then look for the pass line

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert \
    -f exec_pipe.f \
    --top-module exec_pipe_tb \
    -Mdir obj_dir -o vsim \
    > build.log 2>&1 \
    || { cat build.log; echo "verilator build failed"; exit 1; }

./obj_dir/vsim > sim.log 2>&1
cat sim.log

grep -qxF '** PASS **' sim.log && exit 0 || exit 1
